/* proc_consts.svh */
// processor constants
`ifndef PROC_CONSTS_SVH
`define PROC_CONSTS_SVH

`define PROC_DW          16
`define PROC_RAW         3
`define PROC_IAW         8
`define PROC_DAW         8
`define PROC_DMEM_WORDS  256

// instruction fields
`define PROC_OPW         5
`define PROC_OP_LO       11
`define PROC_RS_LO       8
`define PROC_RT_LO       5
`define PROC_RD_LO       2

// opcodes
`define PROC_OP_HALT     5'b00000
`define PROC_OP_NOP      5'b00001
`define PROC_OP_J        5'b00100
`define PROC_OP_ADDI     5'b01000
`define PROC_OP_BEQZ     5'b01100
`define PROC_OP_BNEZ     5'b01101
`define PROC_OP_ST       5'b10000
`define PROC_OP_LD       5'b10001
`define PROC_OP_LBI      5'b11000
`define PROC_OP_RTYPE    5'b11011

// r-format function codes
`define PROC_FN_ADD      2'b00
`define PROC_FN_SUB      2'b01
`define PROC_FN_XOR      2'b10
`define PROC_FN_AND      2'b11

// operand forwarding sources
`define PROC_FWD_NONE    2'd0
`define PROC_FWD_MEM     2'd1
`define PROC_FWD_WB      2'd2

`endif

/* proc_pkg.sv */
// processor types
`default_nettype none
`include "proc_consts.svh"

package proc_pkg;

   typedef enum logic [2:0] {
      ALU_ADD   = 3'd0,
      ALU_SUB   = 3'd1,
      ALU_AND   = 3'd2,
      ALU_XOR   = 3'd3,
      ALU_PASSB = 3'd4
   } alu_op_e;

   typedef enum logic {
      RES_ALU = 1'b0,
      RES_MEM = 1'b1
   } res_sel_e;

   typedef struct packed {
      logic [`PROC_DW-1:0]  instr;
      logic [`PROC_IAW-1:0] pc1;
   } if_id_t;

   typedef struct packed {
      logic [`PROC_DW-1:0]  rs_val;
      logic [`PROC_DW-1:0]  rt_val;
      logic [`PROC_DW-1:0]  imm;
      logic [`PROC_RAW-1:0] rs;
      logic [`PROC_RAW-1:0] rt;
      logic                 has_rt;
      logic [`PROC_RAW-1:0] dest;
      logic                 we;
      alu_op_e              alu_op;
      logic                 use_imm;
      res_sel_e             res_sel;
      logic                 mem_rd;
      logic                 mem_wr;
      logic                 br_z;
      logic                 br_nz;
      logic                 jump;
      logic                 halt;
      logic [`PROC_IAW-1:0] pc1;
   } id_ex_t;

   typedef struct packed {
      logic [`PROC_DW-1:0]  alu_res;
      logic [`PROC_DW-1:0]  st_data;
      logic [`PROC_RAW-1:0] dest;
      logic                 we;
      res_sel_e             res_sel;
      logic                 mem_rd;
      logic                 mem_wr;
      logic                 halt;
   } ex_mem_t;

   typedef struct packed {
      logic [`PROC_DW-1:0]  result;
      logic [`PROC_RAW-1:0] dest;
      logic                 we;
      logic                 halt;
   } mem_wb_t;

endpackage

`default_nettype wire

/* fwd_if.sv */
// forwarding interface
`timescale 1ns/100ps
`default_nettype none
`include "proc_consts.svh"

interface fwd_if;

   logic [1:0]           sel_rs;
   logic [1:0]           sel_rt;
   logic [`PROC_DW-1:0]  fwd_mem_val;
   logic [`PROC_DW-1:0]  fwd_wb_val;
   logic [`PROC_RAW-1:0] rs_num;
   logic [`PROC_RAW-1:0] rt_num;
   logic                 has_rt;

   modport hazard (
      output sel_rs, sel_rt, fwd_mem_val, fwd_wb_val,
      input  rs_num, rt_num, has_rt
   );

   modport execute (
      input  sel_rs, sel_rt, fwd_mem_val, fwd_wb_val,
      output rs_num, rt_num, has_rt
   );

endinterface

`default_nettype wire

/* fetch.sv */
// instruction fetch
`timescale 1ns/100ps
`default_nettype none
`include "proc_consts.svh"

module fetch (
   input  wire                   clk,
   input  wire                   arst_n,
   input  wire                   stall,
   input  wire                   redirect,
   input  wire [`PROC_IAW-1:0]   target,
   input  wire                   halt_seen,
   output logic [`PROC_IAW-1:0]  pc,
   input  wire [`PROC_DW-1:0]    instr,
   output proc_pkg::if_id_t      payload,
   output logic                  valid
);

   logic                 frozen;
   logic [`PROC_IAW-1:0] pc_inc;

   assign pc_inc = pc + 1'b1;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pc     <= '0;
         frozen <= 1'b0;
      end else begin
         if (redirect) begin
            pc <= target;
         end else if (!(stall || halt_seen || frozen)) begin
            pc <= pc_inc;
         end
         // a halt flushed by an older branch must not freeze fetch
         if (redirect) begin
            frozen <= 1'b0;
         end else if (halt_seen) begin
            frozen <= 1'b1;
         end
      end
   end

   always_comb begin
      payload.instr = instr;
      payload.pc1   = pc_inc;
   end

   // nothing younger than a halt enters the pipe
   assign valid = !(frozen || halt_seen);

endmodule

`default_nettype wire

/* pipe_reg.sv */
// pipeline stage register
`timescale 1ns/100ps
`default_nettype none

module pipe_reg #(
   parameter type payload_t = logic
) (
   input  wire           clk,
   input  wire           arst_n,
   input  wire           hold,
   input  wire           flush,
   input  wire payload_t d,
   input  wire           d_valid,
   output payload_t      q,
   output logic          q_valid
);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         q_valid <= 1'b0;
      end else if (flush) begin
         q_valid <= 1'b0;
      end else if (!hold) begin
         q_valid <= d_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (!hold) begin
         q <= d;
      end
   end

endmodule

`default_nettype wire

/* decode.sv */
// instruction decode and register file
`timescale 1ns/100ps
`default_nettype none
`include "proc_consts.svh"

module decode (
   input  wire                   clk,
   input  wire                   arst_n,
   input  wire proc_pkg::if_id_t in_payload,
   input  wire                   in_valid,
   input  wire                   wr_en,
   input  wire [`PROC_RAW-1:0]   wr_reg,
   input  wire [`PROC_DW-1:0]    wr_data,
   output proc_pkg::id_ex_t      out_payload,
   output logic [`PROC_RAW-1:0]  rs_num,
   output logic [`PROC_RAW-1:0]  rt_num,
   output logic                  uses_rt,
   output logic                  halt_seen,
   output logic                  err
);

   logic [`PROC_DW-1:0]  rf [0:(1<<`PROC_RAW)-1];
   logic [`PROC_DW-1:0]  instr;
   logic [`PROC_OPW-1:0] op;
   logic [`PROC_RAW-1:0] rd;
   logic [1:0]           fn;
   logic                 illegal;

   assign instr  = in_payload.instr;
   assign op     = instr[`PROC_OP_LO +: `PROC_OPW];
   assign rs_num = instr[`PROC_RS_LO +: `PROC_RAW];
   assign rt_num = instr[`PROC_RT_LO +: `PROC_RAW];
   assign rd     = instr[`PROC_RD_LO +: `PROC_RAW];
   assign fn     = instr[1:0];

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < (1 << `PROC_RAW); i++) begin
            rf[i] <= '0;
         end
      end else if (wr_en) begin
         rf[wr_reg] <= wr_data;
      end
   end

   always_comb begin
      out_payload         = '0;
      // write-back in the same cycle is seen by the read
      out_payload.rs_val  = (wr_en && wr_reg == rs_num) ? wr_data : rf[rs_num];
      out_payload.rt_val  = (wr_en && wr_reg == rt_num) ? wr_data : rf[rt_num];
      out_payload.imm     = {{(`PROC_DW-5){instr[4]}}, instr[4:0]};
      out_payload.rs      = rs_num;
      out_payload.rt      = rt_num;
      out_payload.dest    = rt_num;
      out_payload.alu_op  = proc_pkg::ALU_ADD;
      out_payload.use_imm = 1'b1;
      out_payload.res_sel = proc_pkg::RES_ALU;
      out_payload.pc1     = in_payload.pc1;
      illegal             = 1'b0;
      case (op)
         `PROC_OP_HALT: out_payload.halt = 1'b1;
         `PROC_OP_NOP: ;
         `PROC_OP_ADDI: out_payload.we = 1'b1;
         `PROC_OP_LD: begin
            out_payload.we      = 1'b1;
            out_payload.mem_rd  = 1'b1;
            out_payload.res_sel = proc_pkg::RES_MEM;
         end
         `PROC_OP_ST: begin
            out_payload.mem_wr = 1'b1;
            out_payload.has_rt = 1'b1;
         end
         `PROC_OP_LBI: begin
            out_payload.we     = 1'b1;
            out_payload.dest   = rs_num;
            out_payload.alu_op = proc_pkg::ALU_PASSB;
            out_payload.imm    = {{(`PROC_DW-8){instr[7]}}, instr[7:0]};
         end
         `PROC_OP_BEQZ, `PROC_OP_BNEZ: begin
            out_payload.br_z  = (op == `PROC_OP_BEQZ);
            out_payload.br_nz = (op == `PROC_OP_BNEZ);
            out_payload.imm   = {{(`PROC_DW-8){instr[7]}}, instr[7:0]};
         end
         `PROC_OP_J: begin
            out_payload.jump = 1'b1;
            out_payload.imm  = {{(`PROC_DW-11){instr[10]}}, instr[10:0]};
         end
         `PROC_OP_RTYPE: begin
            out_payload.we      = 1'b1;
            out_payload.dest    = rd;
            out_payload.has_rt  = 1'b1;
            out_payload.use_imm = 1'b0;
            case (fn)
               `PROC_FN_ADD: out_payload.alu_op = proc_pkg::ALU_ADD;
               `PROC_FN_SUB: out_payload.alu_op = proc_pkg::ALU_SUB;
               `PROC_FN_XOR: out_payload.alu_op = proc_pkg::ALU_XOR;
               default:      out_payload.alu_op = proc_pkg::ALU_AND;
            endcase
         end
         // unknown opcodes travel on as a nop
         default: illegal = 1'b1;
      endcase
   end

   assign uses_rt   = out_payload.has_rt;
   assign halt_seen = in_valid && out_payload.halt;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         err <= 1'b0;
      end else if (in_valid && illegal) begin
         err <= 1'b1;
      end
   end

endmodule

`default_nettype wire

/* execute.sv */
// execute stage
`timescale 1ns/100ps
`default_nettype none
`include "proc_consts.svh"

module execute (
   input  wire proc_pkg::id_ex_t in_payload,
   input  wire                   in_valid,
   fwd_if.execute                fwd,
   output proc_pkg::ex_mem_t     out_payload,
   output logic                  redirect,
   output logic [`PROC_IAW-1:0]  target,
   output logic                  err
);

   logic [`PROC_DW-1:0] rs_val;
   logic [`PROC_DW-1:0] rt_val;
   logic [`PROC_DW-1:0] opb;
   logic [`PROC_DW-1:0] alu_res;
   logic [`PROC_DW-1:0] target_full;

   assign fwd.rs_num = in_payload.rs;
   assign fwd.rt_num = in_payload.rt;
   assign fwd.has_rt = in_payload.has_rt;

   assign rs_val = (fwd.sel_rs == `PROC_FWD_MEM) ? fwd.fwd_mem_val :
                   (fwd.sel_rs == `PROC_FWD_WB)  ? fwd.fwd_wb_val  : in_payload.rs_val;
   assign rt_val = (fwd.sel_rt == `PROC_FWD_MEM) ? fwd.fwd_mem_val :
                   (fwd.sel_rt == `PROC_FWD_WB)  ? fwd.fwd_wb_val  : in_payload.rt_val;
   assign opb    = in_payload.use_imm ? in_payload.imm : rt_val;

   always_comb begin
      case (in_payload.alu_op)
         proc_pkg::ALU_ADD: alu_res = rs_val + opb;
         proc_pkg::ALU_SUB: alu_res = rs_val - opb;
         proc_pkg::ALU_AND: alu_res = rs_val & opb;
         proc_pkg::ALU_XOR: alu_res = rs_val ^ opb;
         default:           alu_res = opb;
      endcase
   end

   // branch condition on rs, target relative to pc+1
   assign redirect = in_valid && (in_payload.jump ||
                                  (in_payload.br_z && rs_val == '0) ||
                                  (in_payload.br_nz && rs_val != '0));
   assign target_full = {{(`PROC_DW-`PROC_IAW){1'b0}}, in_payload.pc1} + in_payload.imm;
   assign target      = target_full[`PROC_IAW-1:0];
   // target falls outside instruction memory
   assign err = redirect && |target_full[`PROC_DW-1:`PROC_IAW];

   always_comb begin
      out_payload.alu_res = alu_res;
      out_payload.st_data = rt_val;
      out_payload.dest    = in_payload.dest;
      out_payload.we      = in_payload.we;
      out_payload.res_sel = in_payload.res_sel;
      out_payload.mem_rd  = in_payload.mem_rd;
      out_payload.mem_wr  = in_payload.mem_wr;
      out_payload.halt    = in_payload.halt;
   end

endmodule

`default_nettype wire

/* mem_stage.sv */
// data memory stage
`timescale 1ns/100ps
`default_nettype none
`include "proc_consts.svh"

module mem_stage (
   input  wire                    clk,
   input  wire                    arst_n,
   input  wire proc_pkg::ex_mem_t in_payload,
   input  wire                    in_valid,
   output proc_pkg::mem_wb_t      out_payload
);

   logic [`PROC_DW-1:0]  dmem [0:`PROC_DMEM_WORDS-1];
   logic [`PROC_DAW-1:0] addr;
   logic                 store;

   assign addr  = in_payload.alu_res[`PROC_DAW-1:0];
   // no stores while in reset
   assign store = arst_n && in_valid && in_payload.mem_wr;

   always_ff @(posedge clk) begin
      if (store) begin
         dmem[addr] <= in_payload.st_data;
      end
   end

   always_comb begin
      out_payload.result = (in_payload.res_sel == proc_pkg::RES_MEM) ? dmem[addr] :
                                                                       in_payload.alu_res;
      out_payload.dest   = in_payload.dest;
      out_payload.we     = in_payload.we;
      out_payload.halt   = in_payload.halt;
   end

endmodule

`default_nettype wire

/* hazard_unit.sv */
// forwarding and load-use stall
`timescale 1ns/100ps
`default_nettype none
`include "proc_consts.svh"

module hazard_unit (
   fwd_if.hazard                  fwd,
   input  wire proc_pkg::id_ex_t  ex_payload,
   input  wire                    ex_valid,
   input  wire proc_pkg::ex_mem_t mem_payload,
   input  wire                    mem_valid,
   input  wire proc_pkg::mem_wb_t wb_payload,
   input  wire                    wb_valid,
   input  wire [`PROC_RAW-1:0]    rs_num,
   input  wire [`PROC_RAW-1:0]    rt_num,
   input  wire                    uses_rt,
   output logic                   stall
);

   logic mem_wr;
   logic wb_wr;

   assign mem_wr = mem_valid && mem_payload.we;
   assign wb_wr  = wb_valid && wb_payload.we;

   assign fwd.fwd_mem_val = mem_payload.alu_res;
   assign fwd.fwd_wb_val  = wb_payload.result;

   // younger producer in ex/mem wins
   always_comb begin
      fwd.sel_rs = `PROC_FWD_NONE;
      if (mem_wr && mem_payload.dest == fwd.rs_num) begin
         fwd.sel_rs = `PROC_FWD_MEM;
      end else if (wb_wr && wb_payload.dest == fwd.rs_num) begin
         fwd.sel_rs = `PROC_FWD_WB;
      end
      fwd.sel_rt = `PROC_FWD_NONE;
      if (fwd.has_rt && mem_wr && mem_payload.dest == fwd.rt_num) begin
         fwd.sel_rt = `PROC_FWD_MEM;
      end else if (fwd.has_rt && wb_wr && wb_payload.dest == fwd.rt_num) begin
         fwd.sel_rt = `PROC_FWD_WB;
      end
   end

   // load data is only ready from mem/wb
   assign stall = ex_valid && ex_payload.mem_rd && ex_payload.we &&
                  (ex_payload.dest == rs_num || (uses_rt && ex_payload.dest == rt_num));

endmodule

`default_nettype wire

/* proc.sv */
// five-stage pipelined processor
`timescale 1ns/100ps
`default_nettype none
`include "proc_consts.svh"

module proc (
   input  wire                   clk,
   input  wire                   arst_n,
   output logic [`PROC_IAW-1:0]  imem_addr,
   input  wire [`PROC_DW-1:0]    imem_data,
   output logic                  wb_valid,
   output logic [`PROC_RAW-1:0]  wb_reg,
   output logic [`PROC_DW-1:0]   wb_data,
   output logic                  halted,
   output logic                  err
);

   proc_pkg::if_id_t     if_pl,  id_pl;
   proc_pkg::id_ex_t     dec_pl, ex_pl;
   proc_pkg::ex_mem_t    exo_pl, mem_pl;
   proc_pkg::mem_wb_t    memo_pl, wb_pl;
   logic                 if_v, id_v, ex_v, mem_v, wb_v;
   logic [`PROC_RAW-1:0] rs_num, rt_num;
   logic                 uses_rt, halt_seen, stall;
   logic                 redirect, dec_err, ex_err;
   logic [`PROC_IAW-1:0] target;

   fwd_if fwd ();

   fetch u_fetch (
      .clk(clk), .arst_n(arst_n), .stall(stall), .redirect(redirect),
      .target(target), .halt_seen(halt_seen), .pc(imem_addr),
      .instr(imem_data), .payload(if_pl), .valid(if_v)
   );

   pipe_reg #(.payload_t(proc_pkg::if_id_t)) u_if_id (
      .clk(clk), .arst_n(arst_n), .hold(stall), .flush(redirect),
      .d(if_pl), .d_valid(if_v), .q(id_pl), .q_valid(id_v)
   );

   decode u_decode (
      .clk(clk), .arst_n(arst_n), .in_payload(id_pl), .in_valid(id_v),
      .wr_en(wb_valid), .wr_reg(wb_reg), .wr_data(wb_data),
      .out_payload(dec_pl), .rs_num(rs_num), .rt_num(rt_num),
      .uses_rt(uses_rt), .halt_seen(halt_seen), .err(dec_err)
   );

   // a stalled instruction leaves a bubble behind it
   pipe_reg #(.payload_t(proc_pkg::id_ex_t)) u_id_ex (
      .clk(clk), .arst_n(arst_n), .hold(1'b0), .flush(redirect || stall),
      .d(dec_pl), .d_valid(id_v), .q(ex_pl), .q_valid(ex_v)
   );

   execute u_execute (
      .in_payload(ex_pl), .in_valid(ex_v), .fwd(fwd.execute),
      .out_payload(exo_pl), .redirect(redirect), .target(target), .err(ex_err)
   );

   pipe_reg #(.payload_t(proc_pkg::ex_mem_t)) u_ex_mem (
      .clk(clk), .arst_n(arst_n), .hold(1'b0), .flush(1'b0),
      .d(exo_pl), .d_valid(ex_v), .q(mem_pl), .q_valid(mem_v)
   );

   mem_stage u_mem (
      .clk(clk), .arst_n(arst_n), .in_payload(mem_pl), .in_valid(mem_v),
      .out_payload(memo_pl)
   );

   // halt parks in write-back until reset
   pipe_reg #(.payload_t(proc_pkg::mem_wb_t)) u_mem_wb (
      .clk(clk), .arst_n(arst_n), .hold(halted), .flush(1'b0),
      .d(memo_pl), .d_valid(mem_v), .q(wb_pl), .q_valid(wb_v)
   );

   hazard_unit u_hazard (
      .fwd(fwd.hazard), .ex_payload(ex_pl), .ex_valid(ex_v),
      .mem_payload(mem_pl), .mem_valid(mem_v),
      .wb_payload(wb_pl), .wb_valid(wb_v),
      .rs_num(rs_num), .rt_num(rt_num), .uses_rt(uses_rt), .stall(stall)
   );

   assign wb_valid = wb_v && wb_pl.we;
   assign wb_reg   = wb_pl.dest;
   assign wb_data  = wb_pl.result;
   assign halted   = wb_v && wb_pl.halt;
   assign err      = dec_err || ex_err;

endmodule

`default_nettype wire

/* proc_checker.sv */
// write-back checker
`timescale 1ns/100ps
`default_nettype none
`include "proc_consts.svh"

module proc_checker (
   input wire                 clk,
   input wire                 wb_valid,
   input wire [`PROC_RAW-1:0] wb_reg,
   input wire [`PROC_DW-1:0]  wb_data,
   input wire                 halted,
   input wire                 err
);

   localparam int PW = `PROC_RAW + `PROC_DW;

   logic [PW-1:0] expq [$];
   logic [PW-1:0] head;
   string         name;
   logic          want_err;
   logic          armed      = 1'b0;
   int            n_expected = 0;
   int            n_seen     = 0;
   int            value_errs = 0;
   int            count_errs = 0;
   int            flag_errs  = 0;
   int            halt_errs  = 0;

   // sampled mid-cycle, one register write per cycle at most
   always @(negedge clk) begin
      if (armed && wb_valid) begin
         n_seen++;
         if (expq.size() == 0) begin
            value_errs++;
            $display("ERR test %s write %0d: expected none, actual r%0d=%h",
                     name, n_seen, wb_reg, wb_data);
         end else begin
            head = expq.pop_front();
            if (head !== {wb_reg, wb_data}) begin
               value_errs++;
               $display("ERR test %s write %0d: expected r%0d=%h, actual r%0d=%h",
                        name, n_seen, head[PW-1 -: `PROC_RAW], head[`PROC_DW-1:0],
                        wb_reg, wb_data);
            end
         end
      end
   end

   task automatic begin_test(input string test, input logic exp_err);
      name       = test;
      want_err   = exp_err;
      n_expected = 0;
      n_seen     = 0;
      expq.delete();
      armed      = 1'b1;
   endtask

   task automatic expect_write(input logic [`PROC_RAW-1:0] r, input logic [`PROC_DW-1:0] v);
      expq.push_back({r, v});
      n_expected++;
   endtask

   task automatic end_test();
      armed = 1'b0;
      if (halted !== 1'b1) begin
         halt_errs++;
         $display("test %s: halted dropped before the end of the test", name);
      end
      if (n_seen != n_expected) begin
         count_errs++;
         $display("ERR test %s write count: expected %0d, actual %0d",
                  name, n_expected, n_seen);
      end
      if (err !== want_err) begin
         flag_errs++;
         $display("ERR test %s err flag: expected %0b, actual %0b", name, want_err, err);
      end
   endtask

   task automatic missing_halt(input int cycles);
      armed = 1'b0;
      halt_errs++;
      $display("test %s: processor did not halt within %0d cycles", name, cycles);
   endtask

   function automatic int total_errors();
      return value_errs + count_errs + flag_errs + halt_errs;
   endfunction

   task automatic print_summary();
      $display("errors: %0d value, %0d write count, %0d err flag, %0d halt, %0d total",
               value_errs, count_errs, flag_errs, halt_errs, total_errors());
   endtask

endmodule

`default_nettype wire

/* tb_proc.sv */
// processor testbench
`timescale 1ns/100ps
`default_nettype none
`include "proc_consts.svh"

module tb_proc;

   localparam int NUM_TESTS   = 5;
   localparam int MAX_WORDS   = 16;
   localparam int RST_CYCLES  = 8;
   localparam int CLK_PERIOD  = 40;
   localparam int HOLD_CYCLES = 4;
   localparam int PW          = `PROC_RAW + `PROC_DW;
   localparam int IMEM_WORDS  = 1 << `PROC_IAW;
   // per test: longest program, drain margin, reset, halt hold and setup
   localparam int WATCHDOG_CYCLES =
      NUM_TESTS * (MAX_WORDS + 20 + RST_CYCLES + HOLD_CYCLES + 4);
   localparam logic [4:0] OP_ILLEGAL = 5'b11111;

   logic                 clk;
   logic                 arst_n;
   logic [`PROC_IAW-1:0] imem_addr;
   wire  [`PROC_DW-1:0]  imem_data;
   logic                 wb_valid;
   logic [`PROC_RAW-1:0] wb_reg;
   logic [`PROC_DW-1:0]  wb_data;
   logic                 halted;
   logic                 err;
   int                   i;

   logic [`PROC_DW-1:0]  imem [0:IMEM_WORDS-1];

   // words and expected writes are listed first to last
   string                         test_name [NUM_TESTS];
   logic                          exp_err   [NUM_TESTS];
   int                            prog_len  [NUM_TESTS];
   int                            wr_len    [NUM_TESTS];
   logic [MAX_WORDS*`PROC_DW-1:0] prog      [NUM_TESTS];
   logic [MAX_WORDS*PW-1:0]       writes    [NUM_TESTS];

   // combinational instruction read
   assign imem_data = imem[imem_addr];

   proc dut (
      .clk(clk), .arst_n(arst_n), .imem_addr(imem_addr), .imem_data(imem_data),
      .wb_valid(wb_valid), .wb_reg(wb_reg), .wb_data(wb_data),
      .halted(halted), .err(err)
   );

   proc_checker chk (
      .clk(clk), .wb_valid(wb_valid), .wb_reg(wb_reg), .wb_data(wb_data),
      .halted(halted), .err(err)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   function automatic logic [15:0] rtype(input int fn, input int rd, input int rs,
                                         input int rt);
      return {`PROC_OP_RTYPE, 3'(rs), 3'(rt), 3'(rd), 2'(fn)};
   endfunction

   // destination or store data in bits 7..5
   function automatic logic [15:0] itype(input int op, input int rd, input int rs,
                                         input int imm);
      return {5'(op), 3'(rs), 3'(rd), 5'(imm)};
   endfunction

   function automatic logic [15:0] branch(input int op, input int rs, input int off);
      return {5'(op), 3'(rs), 8'(off)};
   endfunction

   function automatic logic [15:0] lbi(input int rs, input int imm);
      return {`PROC_OP_LBI, 3'(rs), 8'(imm)};
   endfunction

   function automatic logic [15:0] jump(input int disp);
      return {`PROC_OP_J, 11'(disp)};
   endfunction

   function automatic logic [15:0] bare(input int op);
      return {5'(op), 11'd0};
   endfunction

   function automatic logic [PW-1:0] pair(input int r, input int v);
      return {3'(r), 16'(v)};
   endfunction

   // unused words decode as halt
   function automatic logic [15:0] fill_word(input int addr);
      return {`PROC_OP_HALT, 11'(addr)};
   endfunction

   task automatic set_test(input int t, input string name, input logic want_err,
                           input int words, input int nwr);
      test_name[t] = name;
      exp_err[t]   = want_err;
      prog_len[t]  = words;
      wr_len[t]    = nwr;
   endtask

   task automatic build_table();
      set_test(0, "arith", 1'b0, 10, 9);
      prog[0] = {lbi(1, 'h7f), lbi(2, -128), itype(`PROC_OP_ADDI, 3, 1, 5),
                 rtype(`PROC_FN_ADD, 4, 1, 2), rtype(`PROC_FN_SUB, 5, 1, 2),
                 rtype(`PROC_FN_AND, 6, 4, 1), rtype(`PROC_FN_XOR, 7, 2, 1),
                 rtype(`PROC_FN_ADD, 3, 4, 4), itype(`PROC_OP_ADDI, 2, 2, -1),
                 bare(`PROC_OP_HALT)};
      writes[0] = {pair(1, 'h007f), pair(2, 'hff80), pair(3, 'h0084), pair(4, 'hffff),
                   pair(5, 'h00ff), pair(6, 'h007f), pair(7, 'hffff), pair(3, 'hfffe),
                   pair(2, 'hff7f)};
      set_test(1, "forward", 1'b0, 9, 8);
      prog[1] = {lbi(1, 3), itype(`PROC_OP_ADDI, 2, 1, 4), rtype(`PROC_FN_ADD, 3, 2, 1),
                 rtype(`PROC_FN_SUB, 4, 3, 2), rtype(`PROC_FN_XOR, 5, 1, 4),
                 rtype(`PROC_FN_ADD, 1, 1, 1), rtype(`PROC_FN_ADD, 1, 1, 1),
                 rtype(`PROC_FN_ADD, 6, 1, 1), bare(`PROC_OP_HALT)};
      writes[1] = {pair(1, 3), pair(2, 7), pair(3, 'ha), pair(4, 3), pair(5, 0),
                   pair(1, 6), pair(1, 'hc), pair(6, 'h18)};
      // loads used right away stall once
      set_test(2, "mem_loaduse", 1'b0, 11, 8);
      prog[2] = {lbi(1, 'h10), lbi(2, 'h5a), lbi(3, -2), itype(`PROC_OP_ST, 2, 1, 0),
                 itype(`PROC_OP_ST, 3, 1, 1), itype(`PROC_OP_LD, 4, 1, 0),
                 itype(`PROC_OP_LD, 5, 1, 1), itype(`PROC_OP_ADDI, 6, 5, 1),
                 itype(`PROC_OP_LD, 7, 1, 0), rtype(`PROC_FN_ADD, 6, 1, 7),
                 bare(`PROC_OP_HALT)};
      writes[2] = {pair(1, 'h0010), pair(2, 'h005a), pair(3, 'hfffe), pair(4, 'h005a),
                   pair(5, 'hfffe), pair(6, 'hffff), pair(7, 'h005a), pair(6, 'h006a)};
      // targets are pc+1 plus the offset
      set_test(3, "branch", 1'b0, 15, 5);
      prog[3] = {lbi(1, 0), lbi(2, 5), branch(`PROC_OP_BEQZ, 1, 1), lbi(3, 'h11),
                 branch(`PROC_OP_BNEZ, 1, 1), lbi(4, 'h22), branch(`PROC_OP_BNEZ, 2, 1),
                 lbi(5, 'h33), branch(`PROC_OP_BEQZ, 2, 1), lbi(6, 'h44), jump(2),
                 lbi(7, 'h55), lbi(3, 'h66), rtype(`PROC_FN_ADD, 7, 4, 6),
                 bare(`PROC_OP_HALT)};
      writes[3] = {pair(1, 0), pair(2, 5), pair(4, 'h22), pair(6, 'h44), pair(7, 'h66)};
      set_test(4, "illegal_halt", 1'b1, 6, 2);
      prog[4] = {lbi(1, 9), bare(OP_ILLEGAL), itype(`PROC_OP_ADDI, 2, 1, 1),
                 bare(`PROC_OP_HALT), lbi(3, 'h77), itype(`PROC_OP_ADDI, 4, 1, 2)};
      writes[4] = {pair(1, 9), pair(2, 'ha)};
   endtask

   task automatic run_test(input int t);
      int            a;
      int            cycles;
      int            limit;
      logic [PW-1:0] wr;
      @(posedge clk);
      arst_n <= 1'b0;
      for (a = 0; a < IMEM_WORDS; a++) begin
         if (a < prog_len[t]) begin
            imem[a] <= prog[t][(prog_len[t] - 1 - a) * `PROC_DW +: `PROC_DW];
         end else begin
            imem[a] <= fill_word(a);
         end
      end
      chk.begin_test(test_name[t], exp_err[t]);
      for (a = 0; a < wr_len[t]; a++) begin
         wr = writes[t][(wr_len[t] - 1 - a) * PW +: PW];
         chk.expect_write(wr[PW-1 -: `PROC_RAW], wr[`PROC_DW-1:0]);
      end
      repeat (RST_CYCLES) @(posedge clk);
      arst_n <= 1'b1;
      limit  = prog_len[t] + 20;
      cycles = 0;
      do begin
         @(negedge clk);
         cycles++;
      end while (!halted && cycles < limit);
      if (halted) begin
         // halted stays up and no write follows
         repeat (HOLD_CYCLES) @(posedge clk);
         chk.end_test();
      end else begin
         chk.missing_halt(limit);
      end
   endtask

   initial begin
      arst_n = 1'b0;
      for (i = 0; i < IMEM_WORDS; i++) begin
         imem[i] = fill_word(i);
      end
      build_table();
      for (i = 0; i < NUM_TESTS; i++) begin
         run_test(i);
      end
      chk.print_summary();
      if (chk.total_errors() == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("watchdog: tests still running after %0d cycles", WATCHDOG_CYCLES);
      chk.print_summary();
      $display("Simulation FAILED");
      $finish;
   end

endmodule

`default_nettype wire

/* sim.f */
+incdir+.
proc_pkg.sv
fwd_if.sv
fetch.sv
pipe_reg.sv
decode.sv
execute.sv
mem_stage.sv
hazard_unit.sv
proc.sv
proc_checker.sv
tb_proc.sv
